// File: ptrPkg.sv
// Pointer encoding helpers for the async FIFO
// Address-width function and binary-to-Gray conversion
package ptrPkg;

    // ==================================================
    // Pointer word
    // ==================================================
    localparam int PtrMaxBits = 32;                 // Widest pointer handled
    typedef logic [PtrMaxBits-1:0] ptrWord;         // Carrier for conversions

    // ==================================================
    // Helpers
    // ==================================================
    // Address bits for a power-of-two depth
    function automatic int ptrAddrBits(input int size);
        return $clog2(size);                        // Log2 of Size
    endfunction

    // Gray code of a zero-extended binary pointer
    function automatic ptrWord binToGray(input ptrWord bin);
        return bin ^ (bin >> 1);                    // Adjacent bit XOR
    endfunction

endpackage

// File: linkPkg.sv
// Link defaults shared by the top level and the testbench
// Sample width and FIFO depth
package linkPkg;

    // ==================================================
    // Sample format
    // ==================================================
    parameter int LinkWidth = 12;                   // Bits per sample

    // ==================================================
    // Buffering
    // ==================================================
    // Depth must be a power of two and at least 4
    parameter int LinkDepth = 4;                    // FIFO entries

endpackage

// File: fifoMem.sv
// Dual-port FIFO storage array
// Written on wclk, read combinationally for fall-through
`timescale 1ns/1ps

module fifoMem #(
    parameter int Width = 12,                                   // Word width
    parameter int Size  = 4                                     // Entries
) (
    input  logic                                   wclk,        // Write clock
    input  logic                                   wInc,        // Write enable
    input  logic [ptrPkg::ptrAddrBits(Size)-1:0]   wAddr,       // Write address
    input  logic [Width-1:0]                       wd,          // Write data
    input  logic [ptrPkg::ptrAddrBits(Size)-1:0]   rAddr,       // Read address
    output logic [Width-1:0]                       rd           // Head word
);

    logic [Width-1:0] mem [Size];                               // Storage

    // ==================================================
    // Write port
    // ==================================================
    always_ff @(posedge wclk) begin
        if (wInc) begin                                         // Accepted write
            mem[wAddr] <= wd;
        end
    end

    // ==================================================
    // Read port
    // ==================================================
    assign rd = mem[rAddr];                                     // Head word always visible

endmodule

// File: grayPtr.sv
// FIFO pointer counter with binary and registered Gray outputs
`timescale 1ns/1ps

module grayPtr #(
    parameter int Size = 4                                      // FIFO depth
) (
    input  logic                                   clk,         // Domain clock
    input  logic                                   aempty,      // Async reset
    input  logic                                   inc,         // Advance enable
    output logic [ptrPkg::ptrAddrBits(Size)-1:0]   binPtr,      // Binary pointer
    output logic [ptrPkg::ptrAddrBits(Size)-1:0]   grayPtr      // Gray pointer
);

    import ptrPkg::*;

    localparam int AddrBits = ptrAddrBits(Size);                // Pointer width

    logic [AddrBits-1:0] binNext;                               // Incremented pointer
    logic [AddrBits-1:0] grayNext;                              // Its Gray code

    assign binNext  = binPtr + 1'b1;                            // Wraps at Size
    assign grayNext = AddrBits'(binToGray(ptrWord'(binNext)));  // Truncate to width

    // ==================================================
    // Pointer registers
    // ==================================================
    always_ff @(posedge clk or posedge aempty) begin
        if (aempty) begin
            binPtr  <= '0;                                      // Both start at zero
            grayPtr <= '0;
        end else if (inc) begin
            binPtr  <= binNext;                                 // Advance together
            grayPtr <= grayNext;                                // Registered, glitch free
        end
    end

endmodule

// File: asyncFlags.sv
// Direction latch, asynchronous empty/full decode
// Two-flop flag release in each clock domain
`timescale 1ns/1ps

module asyncFlags #(
    parameter int Size = 4                                      // FIFO depth
) (
    input  logic                                   rclk,        // Read clock
    input  logic                                   wclk,        // Write clock
    input  logic                                   aempty,      // Async reset
    input  logic [ptrPkg::ptrAddrBits(Size)-1:0]   rGray,       // Read Gray pointer
    input  logic [ptrPkg::ptrAddrBits(Size)-1:0]   wGray,       // Write Gray pointer
    output logic                                   emptyFlag,   // Read domain
    output logic                                   fullFlag     // Write domain
);

    import ptrPkg::*;

    localparam int Msb = ptrAddrBits(Size) - 1;                 // Top Gray bit

    logic dirFlag;                                              // Set when heading full
    logic dirSet;                                               // Writer one quadrant behind
    logic dirClr;                                               // Writer one quadrant ahead
    logic dirReset;                                             // Clear or reset
    logic ptrMatch;                                             // Pointers equal
    logic asyncEmpty;                                           // Raw empty condition
    logic asyncFull;                                            // Raw full condition
    logic emptyPreset;                                          // Read chain preset
    logic fullPreset;                                           // Write chain preset
    logic emptySync;                                            // First empty stage
    logic fullSync;                                             // First full stage

    // ==================================================
    // Quadrant decode and direction latch
    // ==================================================
    // Top two Gray bits step 00 01 11 10 around the ring
    assign dirSet   = (wGray[Msb] ^ rGray[Msb-1]) & ~(wGray[Msb-1] ^ rGray[Msb]);
    assign dirClr   = ~(wGray[Msb] ^ rGray[Msb-1]) & (wGray[Msb-1] ^ rGray[Msb]);
    assign dirReset = dirClr | aempty;                          // Clear wins

    always_ff @(posedge dirSet or posedge dirReset) begin
        if (dirReset) begin
            dirFlag <= 1'b0;                                    // Heading empty
        end else begin
            dirFlag <= 1'b1;                                    // Heading full
        end
    end

    // ==================================================
    // Asynchronous compare
    // ==================================================
    assign ptrMatch    = (rGray == wGray);
    assign asyncEmpty  = ptrMatch & ~dirFlag;                   // Reader caught writer
    assign asyncFull   = ptrMatch & dirFlag;                    // Writer caught reader
    assign emptyPreset = asyncEmpty | aempty;
    assign fullPreset  = asyncFull | aempty;

    // ==================================================
    // Flag release chains
    // ==================================================
    always_ff @(posedge rclk or posedge emptyPreset) begin
        if (emptyPreset) begin
            {emptyFlag, emptySync} <= 2'b11;                    // Set at once
        end else begin
            {emptyFlag, emptySync} <= {emptySync, 1'b0};        // Release after two edges
        end
    end

    always_ff @(posedge wclk or posedge fullPreset) begin
        if (fullPreset) begin
            {fullFlag, fullSync} <= 2'b11;                      // Set at once
        end else begin
            {fullFlag, fullSync} <= {fullSync, 1'b0};           // Release after two edges
        end
    end

endmodule

// File: asyncFifo.sv
// Asynchronous FIFO core with storage, pointers, flags
// Strobe gating and ok outputs
`timescale 1ns/1ps

module asyncFifo #(
    parameter int Width = 12,                                   // Word width
    parameter int Size  = 4                                     // Entries
) (
    input  logic             rclk,                              // Read clock
    input  logic             wclk,                              // Write clock
    input  logic             aempty,                            // Async reset
    input  logic             r,                                 // Read strobe
    output logic [Width-1:0] rd,                                // Read data
    output logic             rok,                               // Data available
    input  logic             w,                                 // Write strobe
    input  logic [Width-1:0] wd,                                // Write data
    output logic             wok                                // Space available
);

    import ptrPkg::*;

    localparam int AddrBits = ptrAddrBits(Size);                // Pointer width

    logic [AddrBits-1:0] wBin;                                  // Write address
    logic [AddrBits-1:0] wGray;                                 // Write Gray pointer
    logic [AddrBits-1:0] rBin;                                  // Read address
    logic [AddrBits-1:0] rGray;                                 // Read Gray pointer
    logic                emptyFlag;                             // From read chain
    logic                fullFlag;                              // From write chain
    logic                wInc;                                  // Accepted write
    logic                rInc;                                  // Accepted read

    // ==================================================
    // Accept logic
    // ==================================================
    assign wInc = w & ~fullFlag;                                // Drop w when full
    assign rInc = r & ~emptyFlag;                               // Drop r when empty
    assign wok  = ~fullFlag;
    assign rok  = ~emptyFlag;

    // ==================================================
    // Storage and pointers
    // ==================================================
    fifoMem #(
        .Width (Width),
        .Size  (Size)
    ) i_mem (
        .wclk  (wclk),
        .wInc  (wInc),
        .wAddr (wBin),
        .wd    (wd),
        .rAddr (rBin),
        .rd    (rd)
    );

    grayPtr #(
        .Size    (Size)
    ) i_wPtr (
        .clk     (wclk),                                        // Write domain
        .aempty  (aempty),
        .inc     (wInc),
        .binPtr  (wBin),
        .grayPtr (wGray)
    );

    grayPtr #(
        .Size    (Size)
    ) i_rPtr (
        .clk     (rclk),                                        // Read domain
        .aempty  (aempty),
        .inc     (rInc),
        .binPtr  (rBin),
        .grayPtr (rGray)
    );

    // ==================================================
    // Flags
    // ==================================================
    asyncFlags #(
        .Size      (Size)
    ) i_flags (
        .rclk      (rclk),
        .wclk      (wclk),
        .aempty    (aempty),
        .rGray     (rGray),
        .wGray     (wGray),
        .emptyFlag (emptyFlag),
        .fullFlag  (fullFlag)
    );

endmodule

// File: cdcLink.sv
// Clock-domain crossing link top level
// Sample stream from wclk to rclk through the async FIFO
`timescale 1ns/1ps

module cdcLink #(
    parameter int Width = linkPkg::LinkWidth,                   // Sample width
    parameter int Size  = linkPkg::LinkDepth                    // FIFO depth
) (
    // Read domain
    input  logic             rclk,                              // Read clock
    input  logic             aempty,                            // Async reset, both domains
    input  logic             r,                                 // Read strobe
    output logic [Width-1:0] rd,                                // Head sample
    output logic             rok,                               // Sample available
    // Write domain
    input  logic             wclk,                              // Write clock
    input  logic             w,                                 // Write strobe
    input  logic [Width-1:0] wd,                                // New sample
    output logic             wok                                // Room available
);

    // ==================================================
    // Crossing FIFO
    // ==================================================
    asyncFifo #(
        .Width  (Width),
        .Size   (Size)
    ) i_fifo (
        .rclk   (rclk),
        .wclk   (wclk),
        .aempty (aempty),
        .r      (r),
        .rd     (rd),
        .rok    (rok),
        .w      (w),
        .wd     (wd),
        .wok    (wok)
    );

endmodule

// File: tb_cdcLink.sv
// Testbench for the CDC link with random producer and consumer
// Queue model, full/empty phases, mid-run reset
`timescale 1ns/1ps

module tb_cdcLink;

    import linkPkg::*;

    // ==================================================
    // Run length and limits
    // ==================================================
    localparam int unsigned Seed = 32'hebe11cb5;
    localparam int RandCycles = 300;                            // Read clocks per random phase
    localparam int PlannedOps = 2 * RandCycles + 16 * LinkDepth + 100;
    localparam int ClockRatio = 2;                              // 10 ns over 7 ns rounded up
    localparam int CycleLimit = 4 * PlannedOps * ClockRatio;

    logic                 rclk = 1'b0;
    logic                 wclk = 1'b0;
    logic                 aempty = 1'b1;                        // Reset from time zero
    logic                 r = 1'b0;
    logic                 w = 1'b0;
    logic [LinkWidth-1:0] wd = '0;
    logic [LinkWidth-1:0] rd;
    logic                 rok;
    logic                 wok;

    logic [LinkWidth-1:0] model [$];                            // Words in flight
    int                   wMode = 0;                            // 0 idle, 1 random, 2 always
    int                   rMode = 0;
    int                   pushes = 0;
    int                   pops = 0;
    int                   errors = 0;
    int                   checks = 0;
    int                   cycles = 0;
    int                   base;

    always #5 rclk = ~rclk;                                     // 10 ns
    always #3.5 wclk = ~wclk;                                   // 7 ns so posedges never meet rclk

    cdcLink i_dut (
        .rclk   (rclk),
        .aempty (aempty),
        .r      (r),
        .rd     (rd),
        .rok    (rok),
        .wclk   (wclk),
        .w      (w),
        .wd     (wd),
        .wok    (wok)
    );

    task automatic compare(input string what, input logic [31:0] got, input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Error at %0t ns: %s, got %0h expected %0h", $time, what, got, exp);
        end
    endtask

    // ==================================================
    // Stimulus on falling edges
    // ==================================================
    always @(negedge wclk) begin
        case (wMode)
            0:       w = 1'b0;
            1:       w = ($urandom % 2) == 0;
            default: w = 1'b1;
        endcase
        wd = LinkWidth'($urandom);                              // New word every cycle
    end

    always @(negedge rclk) begin
        case (rMode)
            0:       r = 1'b0;
            1:       r = ($urandom % 4) != 0;
            default: r = 1'b1;
        endcase
    end

    // ==================================================
    // Model and monitors
    // ==================================================
    always @(posedge wclk) begin
        if (!aempty) begin
            if (model.size() == LinkDepth) begin
                compare("wok high while model full", 32'(wok), 32'd0);
            end
            if (w && wok) begin                                 // Accepted write
                model.push_back(wd);
                pushes++;
            end
        end
    end

    always @(posedge rclk) begin
        if (!aempty) begin
            if (model.size() == 0) begin
                compare("rok high while model empty", 32'(rok), 32'd0);
            end
            if (r && rok) begin
                if (model.size() == 0) begin
                    errors++;
                    $display("Read accepted at %0t ns with nothing stored in the model", $time);
                end else begin
                    compare("read data", 32'(rd), 32'(model.pop_front()));
                    pops++;
                end
            end
        end
    end

    always @(posedge rclk) begin
        cycles++;
        if (cycles >= CycleLimit) begin
            $display("Timeout: run did not finish within %0d read clock cycles", CycleLimit);
            $display("Simulation failed");
            $finish;
        end
    end

    // ==================================================
    // Phase tasks
    // ==================================================
    // Hold reset 3 read cycles and release off both clock edges
    task automatic holdReset;
        repeat (3) begin
            @(negedge rclk);
            compare("rok during reset", 32'(rok), 32'd0);
            compare("wok during reset", 32'(wok), 32'd0);
        end
        #0.4;
        aempty = 1'b0;
    endtask

    task automatic checkRelease;
        repeat (3) begin
            @(negedge wclk);
            compare("rok after release", 32'(rok), 32'd0);  // Nothing written yet
        end
        compare("wok after release", 32'(wok), 32'd1);
    endtask

    task automatic runRandom(input int n);
        wMode = 1;
        rMode = 1;
        repeat (n) @(posedge rclk);
    endtask

    task automatic drainLink;
        wMode = 0;
        repeat (2) @(posedge wclk);                             // Let last write land
        rMode = 2;
        while (model.size() != 0) @(posedge rclk);
        rMode = 0;
        repeat (2) @(posedge rclk);
        @(negedge rclk);
        compare("rok after drain", 32'(rok), 32'd0);
    endtask

    task automatic fillAndEmpty;
        while (!wok) @(posedge wclk);
        base = pushes;
        wMode = 2;                                              // Keeps writing past full
        repeat (4 * LinkDepth) @(posedge wclk);
        wMode = 0;
        compare("writes accepted until full", 32'(pushes - base), 32'(LinkDepth));
        @(negedge wclk);
        compare("wok once full", 32'(wok), 32'd0);
        base = pops;
        rMode = 2;                                              // Keeps reading past empty
        repeat (4 * LinkDepth) @(posedge rclk);
        rMode = 0;
        compare("reads accepted until empty", 32'(pops - base), 32'(LinkDepth));
        @(negedge rclk);
        compare("rok once empty", 32'(rok), 32'd0);
    endtask

    task automatic midRunReset;
        wMode = 2;
        repeat (3) @(posedge wclk);
        wMode = 0;
        while (!rok) @(posedge rclk);                           // Data now visible
        @(negedge rclk);
        #0.4;
        aempty = 1'b1;
        model.delete();                                         // Stored words are lost
        #0.1;
        compare("rok at mid-run reset", 32'(rok), 32'd0);
        holdReset();
        checkRelease();
    endtask

    // ==================================================
    // Main sequence
    // ==================================================
    initial begin
        void'($urandom(Seed));
        holdReset();
        checkRelease();
        runRandom(RandCycles);
        drainLink();
        fillAndEmpty();
        midRunReset();
        runRandom(RandCycles);
        drainLink();
        $display("Checks: %0d, errors: %0d, writes: %0d, reads: %0d",
                 checks, errors, pushes, pops);
        if (errors == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

// File: cdcLink.f
ptrPkg.sv
linkPkg.sv
fifoMem.sv
grayPtr.sv
asyncFlags.sv
asyncFifo.sv
cdcLink.sv
tb_cdcLink.sv

// File: run.sh
#!/bin/sh
# Build and run the cdcLink testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -j 0 --top-module tb_cdcLink -f cdcLink.f \
    -o tb_cdcLink > build.log 2>&1 \
    && ./obj_dir/tb_cdcLink > sim.log 2>&1 \
    || { echo "Build or run error, see build.log and sim.log"; exit 1; }

grep -q "Simulation passed" sim.log && echo "PASS" || { echo "FAIL, see sim.log"; exit 1; }
